//--- verilog/st_sink_defines.svh
/*
 * streaming sink capture widths, depths and default ready latency
 */

`ifndef ST_SINK_DEFINES_SVH
`define ST_SINK_DEFINES_SVH

// ----------------------------------------
// beat payload
// ----------------------------------------
`define ST_SYMBOL_W 8
`define ST_NUMSYMBOLS 4
`define ST_DATA_W (`ST_SYMBOL_W * `ST_NUMSYMBOLS)
`define ST_CHANNEL_W 4
`define ST_ERROR_W 2
// unused symbols in an eop beat
`define ST_EMPTY_W 2

// ----------------------------------------
// capture side
// ----------------------------------------
// idle counter saturates at all ones
`define ST_IDLE_W 16
`define ST_MAX_READY_DELAY 8
`define ST_READY_LATENCY_DEFAULT 1
`define ST_FIFO_DEPTH 8
// must hold 0 .. ST_FIFO_DEPTH
`define ST_LEVEL_W 4

`endif

//--- verilog/st_sink_pkg.sv
/*
 * streaming sink capture types
 * field vectors, the unpacked beat and the queued record
 */

`include "st_sink_defines.svh"

package st_sink_pkg;

   // ----------------------------------------
   // field types
   // ----------------------------------------
   typedef logic [`ST_DATA_W-1:0]    st_data_t;
   typedef logic [`ST_CHANNEL_W-1:0] st_channel_t;
   typedef logic [`ST_ERROR_W-1:0]   st_error_t;
   typedef logic [`ST_EMPTY_W-1:0]   st_empty_t;
   typedef logic [`ST_IDLE_W-1:0]    st_idle_t;
   // record count in the queue
   typedef logic [`ST_LEVEL_W-1:0]   st_level_t;

   // ----------------------------------------
   // one accepted beat, 42 bits
   // ----------------------------------------
   typedef struct packed {
      st_data_t    data;
      st_channel_t channel;
      logic        sop;
      logic        eop;
      st_error_t   error;
      st_empty_t   empty;
   } st_beat_t;

   // ----------------------------------------
   // queued record, 58 bits
   // ----------------------------------------
   // idles = idle cycles seen before the beat
   typedef struct packed {
      st_idle_t idles;
      st_beat_t beat;
   } st_record_t;

endpackage

//--- verilog/st_beat_decode.sv
/*
 * streaming sink beat decode
 * ready latency delay chain, valid qualification and beat unpacking
 */

`timescale 1ns/100ps

`include "st_sink_defines.svh"

module st_beat_decode #(
   parameter int ready_latency = `ST_READY_LATENCY_DEFAULT
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sink_valid,
   input  logic                   ready_ctl,
   input  st_sink_pkg::st_data_t    sink_data,
   input  st_sink_pkg::st_channel_t sink_channel,
   input  logic                   sink_startofpacket,
   input  logic                   sink_endofpacket,
   input  st_sink_pkg::st_error_t   sink_error,
   input  st_sink_pkg::st_empty_t   sink_empty,
   output logic                   accept,
   output st_sink_pkg::st_beat_t    beat,
   output logic                   valid_q,
   output logic                   ready_q_d1
);

   // tap into the delay chain, latency 0 bypasses it
   localparam int tap = (ready_latency > 0) ? ready_latency - 1 : 0;

   logic [`ST_MAX_READY_DELAY-1:0] ready_dly;
   logic                           ready_q;
   st_sink_pkg::st_beat_t          beat_in;

   // ----------------------------------------
   // ready qualification
   // ----------------------------------------
   // chain starts empty, so qualified ready stays low until it fills
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_dly <= '0;
      end else begin
         ready_dly <= {ready_dly[`ST_MAX_READY_DELAY-2:0], ready_ctl};
      end
   end

   assign ready_q = (ready_latency == 0) ? ready_ctl : ready_dly[tap];

   // every valid pin is present, so valid qualifies as is
   assign valid_q = sink_valid;

   // delayed qualified ready for idle counting
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q_d1 <= 1'b0;
      end else begin
         ready_q_d1 <= ready_q;
      end
   end

   // ----------------------------------------
   // beat capture
   // ----------------------------------------
   always_comb begin
      beat_in.data    = sink_data;
      beat_in.channel = sink_channel;
      beat_in.sop     = sink_startofpacket;
      beat_in.eop     = sink_endofpacket;
      beat_in.error   = sink_error;
      beat_in.empty   = sink_empty;
   end

   // valid without qualified ready is dropped, not held
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         accept <= 1'b0;
      end else begin
         accept <= valid_q & ready_q;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_q && ready_q) begin
         beat <= beat_in;
      end
   end

   // chain is only ST_MAX_READY_DELAY deep
   a_latency_range : assert property (
      @(posedge clk) ready_latency <= `ST_MAX_READY_DELAY
   );

endmodule

//--- verilog/st_idle_tagger.sv
/*
 * idle tagger
 * counts idle cycles and stamps each accepted beat into a record
 */

`timescale 1ns/100ps

module st_idle_tagger (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    accept,
   input  st_sink_pkg::st_beat_t   beat,
   input  logic                    valid_q,
   input  logic                    ready_q_d1,
   output logic                    wr,
   output st_sink_pkg::st_record_t wr_rec
);

   st_sink_pkg::st_idle_t idle_cnt;
   st_sink_pkg::st_idle_t idle_snap;

   // ----------------------------------------
   // idle counter
   // ----------------------------------------
   // counts ready cycles without valid, any other cycle clears it
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idle_cnt <= '0;
      end else if (ready_q_d1 && !valid_q) begin
         // saturate at all ones
         if (idle_cnt != '1) begin
            idle_cnt <= idle_cnt + st_sink_pkg::st_idle_t'(1);
         end
      end else begin
         idle_cnt <= '0;
      end
   end

   // count as it stood before the acceptance edge
   // decode's accept arrives one edge later
   always_ff @(posedge clk) begin
      idle_snap <= idle_cnt;
   end

   // ----------------------------------------
   // record stamp
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr <= 1'b0;
      end else begin
         wr <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wr_rec.idles <= idle_snap;
         wr_rec.beat  <= beat;
      end
   end

   a_wr_after_accept : assert property (
      @(posedge clk) disable iff (reset) wr |-> $past(accept)
   );

endmodule

//--- verilog/st_record_fifo.sv
/*
 * record queue
 * fixed depth circular buffer with pop, fill level and sticky overflow
 */

`timescale 1ns/100ps

`include "st_sink_defines.svh"

module st_record_fifo (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    wr,
   input  st_sink_pkg::st_record_t wr_rec,
   input  logic                    pop,
   output st_sink_pkg::st_record_t rec,
   output logic                    rec_valid,
   output st_sink_pkg::st_level_t  level,
   output logic                    overflow
);

   localparam int ptr_w = $clog2(`ST_FIFO_DEPTH);
   localparam st_sink_pkg::st_level_t full_level = st_sink_pkg::st_level_t'(`ST_FIFO_DEPTH);

   st_sink_pkg::st_record_t mem [`ST_FIFO_DEPTH];
   logic [ptr_w-1:0]        wr_ptr;
   logic [ptr_w-1:0]        rd_ptr;
   logic                    full;
   logic                    do_pop;
   logic                    do_wr;

   // ----------------------------------------
   // flags
   // ----------------------------------------
   assign rec_valid = (level != '0);
   assign full      = (level == full_level);

   // pop on an empty queue is ignored
   assign do_pop = pop & rec_valid;
   // full queue still takes a write when the head leaves the same edge
   assign do_wr  = wr & (~full | do_pop);

   // head is read straight from storage
   assign rec = mem[rd_ptr];

   // ----------------------------------------
   // storage
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_rec;
      end
   end

   // ----------------------------------------
   // pointers and level
   // ----------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == ptr_w'(`ST_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(`ST_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         level <= '0;
      end else begin
         case ({do_wr, do_pop})
            2'b10:   level <= level + st_sink_pkg::st_level_t'(1);
            2'b01:   level <= level - st_sink_pkg::st_level_t'(1);
            // both or neither, count unchanged
            default: level <= level;
         endcase
      end
   end

   // ----------------------------------------
   // overflow
   // ----------------------------------------
   // dropped write sets the flag until reset
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         overflow <= 1'b0;
      end else if (wr && !do_wr) begin
         overflow <= 1'b1;
      end
   end

   a_level_bound : assert property (
      @(posedge clk) disable iff (reset) level <= full_level
   );

endmodule

//--- verilog/st_sink_capture.sv
/*
 * streaming sink capture top
 * decode, idle tagging and record queue
 */

`timescale 1ns/100ps

`include "st_sink_defines.svh"

module st_sink_capture #(
   parameter int ready_latency = `ST_READY_LATENCY_DEFAULT
) (
   input  logic                     clk,
   input  logic                     reset,
   // streaming beat
   input  st_sink_pkg::st_data_t    sink_data,
   input  st_sink_pkg::st_channel_t sink_channel,
   input  logic                     sink_valid,
   input  logic                     sink_startofpacket,
   input  logic                     sink_endofpacket,
   input  st_sink_pkg::st_error_t   sink_error,
   input  st_sink_pkg::st_empty_t   sink_empty,
   output logic                     sink_ready,
   // client side
   input  logic                     ready_ctl,
   input  logic                     pop,
   output st_sink_pkg::st_record_t  rec,
   output logic                     rec_valid,
   output st_sink_pkg::st_level_t   level,
   output logic                     overflow
);

   logic                    accept;
   st_sink_pkg::st_beat_t   beat;
   logic                    valid_q;
   logic                    ready_q_d1;
   logic                    wr;
   st_sink_pkg::st_record_t wr_rec;

   // back pressure goes out undelayed
   assign sink_ready = ready_ctl;

   // ----------------------------------------
   // decode
   // ----------------------------------------
   st_beat_decode #(
      .ready_latency(ready_latency)
   ) u_decode (
      .clk               (clk),
      .reset             (reset),
      .sink_valid        (sink_valid),
      .ready_ctl         (ready_ctl),
      .sink_data         (sink_data),
      .sink_channel      (sink_channel),
      .sink_startofpacket(sink_startofpacket),
      .sink_endofpacket  (sink_endofpacket),
      .sink_error        (sink_error),
      .sink_empty        (sink_empty),
      .accept            (accept),
      .beat              (beat),
      .valid_q           (valid_q),
      .ready_q_d1        (ready_q_d1)
   );

   // ----------------------------------------
   // execute and result
   // ----------------------------------------
   st_idle_tagger u_tagger (
      .clk       (clk),
      .reset     (reset),
      .accept    (accept),
      .beat      (beat),
      .valid_q   (valid_q),
      .ready_q_d1(ready_q_d1),
      .wr        (wr),
      .wr_rec    (wr_rec)
   );

   st_record_fifo u_fifo (
      .clk      (clk),
      .reset    (reset),
      .wr       (wr),
      .wr_rec   (wr_rec),
      .pop      (pop),
      .rec      (rec),
      .rec_valid(rec_valid),
      .level    (level),
      .overflow (overflow)
   );

endmodule

//--- test/st_sink_capture_tb.sv
/*
 * streaming sink capture testbench
 * replays the golden file and checks popped records, level and overflow
 */

`timescale 1ns/100ps

module st_sink_capture_tb;

   logic                     clk;
   logic                     reset;
   st_sink_pkg::st_data_t    sink_data;
   st_sink_pkg::st_channel_t sink_channel;
   logic                     sink_valid;
   logic                     sink_startofpacket;
   logic                     sink_endofpacket;
   st_sink_pkg::st_error_t   sink_error;
   st_sink_pkg::st_empty_t   sink_empty;
   logic                     sink_ready;
   logic                     ready_ctl;
   logic                     pop;
   st_sink_pkg::st_record_t  rec;
   logic                     rec_valid;
   st_sink_pkg::st_level_t   level;
   logic                     overflow;

   st_sink_pkg::st_record_t  exp_rec;
   reg [8*128-1:0]           line;
   reg [8*8-1:0]             kind;
   reg [8*16-1:0]            name;
   reg [8*16-1:0]            cur_name;
   reg [31:0]                dat;
   reg [31:0]                ch;
   integer fd, n, cnt, v, r, p, sop, eop, er, em, idl, val, i;
   integer cycle_cnt, cycle_limit;
   integer errors, checks, tests, test_errs, test_checks;

   st_sink_capture #(
      .ready_latency(1)
   ) dut (
      .clk               (clk),
      .reset             (reset),
      .sink_data         (sink_data),
      .sink_channel      (sink_channel),
      .sink_valid        (sink_valid),
      .sink_startofpacket(sink_startofpacket),
      .sink_endofpacket  (sink_endofpacket),
      .sink_error        (sink_error),
      .sink_empty        (sink_empty),
      .sink_ready        (sink_ready),
      .ready_ctl         (ready_ctl),
      .pop               (pop),
      .rec               (rec),
      .rec_valid         (rec_valid),
      .level             (level),
      .overflow          (overflow)
   );

   // ----------------------------------------
   // clock and timeout
   // ----------------------------------------
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // limit is zero until the golden file has been sized
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
         $display("timeout: run went past %0d cycles", cycle_limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   // inputs change 5 ns after the edge
   task automatic next_cycle;
      @(posedge clk);
      #5;
   endtask

   task automatic drive_beat(input integer dv, input integer dr, input integer dp,
                             input reg [31:0] dd, input reg [31:0] dc,
                             input integer ds, input integer de,
                             input integer derr, input integer demp);
      sink_valid         = dv[0];
      ready_ctl          = dr[0];
      pop                = dp[0];
      sink_data          = dd;
      sink_channel       = st_sink_pkg::st_channel_t'(dc);
      sink_startofpacket = ds[0];
      sink_endofpacket   = de[0];
      sink_error         = st_sink_pkg::st_error_t'(derr);
      sink_empty         = st_sink_pkg::st_empty_t'(demp);
   endtask

   task automatic check_value(input reg [8*16-1:0] tname, input reg [8*16-1:0] what,
                              input reg [63:0] expv, input reg [63:0] actv);
      checks      = checks + 1;
      test_checks = test_checks + 1;
      if (expv !== actv) begin
         $display("mismatch %0s %0s: expected %h, actual %h", tname, what, expv, actv);
         errors    = errors + 1;
         test_errs = test_errs + 1;
      end
   endtask

   // one summary line per test
   task automatic close_test;
      if (cur_name != 0) begin
         tests = tests + 1;
         if (test_errs == 0) begin
            $display("test %0s: pass, %0d checks", cur_name, test_checks);
         end else begin
            $display("test %0s: fail, %0d of %0d checks wrong", cur_name, test_errs,
                     test_checks);
         end
      end
      test_errs   = 0;
      test_checks = 0;
   endtask

   // ----------------------------------------
   // golden replay
   // ----------------------------------------
   // first pass sizes the run for the timeout
   task automatic size_run;
      cnt = 0;
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && $sscanf(line, "%s %s %d", kind, name, cnt) >= 2) begin
            if (kind == "C") cycle_limit = cycle_limit + cnt;
            if (kind == "P") cycle_limit = cycle_limit + 1;
            if (kind == "X") cycle_limit = cycle_limit + 2;
         end
      end
      $fclose(fd);
      // reset cycles and margin
      cycle_limit = cycle_limit + 2 + 50;
   endtask

   task automatic replay_golden;
      fd = $fopen("test/st_sink_golden.txt", "r");
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && $sscanf(line, "%s %s", kind, name) == 2 && kind != "#") begin
            if (name != cur_name) begin
               close_test();
               cur_name = name;
            end
            if (kind == "C") begin
               n = $sscanf(line, "%s %s %d %d %d %d %h %h %d %d %d %d", kind, name, cnt,
                           v, r, p, dat, ch, sop, eop, er, em);
               drive_beat(v, r, p, dat, ch, sop, eop, er, em);
               for (i = 0; i < cnt; i = i + 1) begin
                  next_cycle();
               end
               // sink_ready follows ready_ctl with no delay
               check_value(name, "sink_ready", 64'(r[0]), 64'(sink_ready));
            end else if (kind == "P") begin
               n = $sscanf(line, "%s %s %d %h %h %d %d %d %d", kind, name, idl, dat, ch,
                           sop, eop, er, em);
               exp_rec.idles        = st_sink_pkg::st_idle_t'(idl);
               exp_rec.beat.data    = dat;
               exp_rec.beat.channel = st_sink_pkg::st_channel_t'(ch);
               exp_rec.beat.sop     = sop[0];
               exp_rec.beat.eop     = eop[0];
               exp_rec.beat.error   = st_sink_pkg::st_error_t'(er);
               exp_rec.beat.empty   = st_sink_pkg::st_empty_t'(em);
               if (!rec_valid) begin
                  $display("test %0s: pop found the record queue empty", name);
                  checks      = checks + 1;
                  test_checks = test_checks + 1;
                  errors      = errors + 1;
                  test_errs   = test_errs + 1;
               end else begin
                  check_value(name, "record", 64'(exp_rec), 64'(rec));
               end
               // pop strobe for one cycle, ready held
               drive_beat(0, ready_ctl, 1, 0, 0, 0, 0, 0, 0);
               next_cycle();
               pop = 1'b0;
            end else if (kind == "L") begin
               n = $sscanf(line, "%s %s %d", kind, name, val);
               check_value(name, "level", 64'(val), 64'(level));
            end else if (kind == "V") begin
               n = $sscanf(line, "%s %s %d", kind, name, val);
               check_value(name, "rec_valid", 64'(val), 64'(rec_valid));
            end else if (kind == "O") begin
               n = $sscanf(line, "%s %s %d", kind, name, val);
               check_value(name, "overflow", 64'(val), 64'(overflow));
            end else if (kind == "X") begin
               drive_beat(0, ready_ctl, 0, 0, 0, 0, 0, 0, 0);
               reset = 1'b1;
               next_cycle();
               next_cycle();
               reset = 1'b0;
            end else begin
               $display("unknown line kind in golden file for test %0s", name);
               errors = errors + 1;
            end
         end
      end
      $fclose(fd);
      close_test();
   endtask

   initial begin
      cycle_cnt   = 0;
      cycle_limit = 0;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      test_errs   = 0;
      test_checks = 0;
      cur_name    = 0;
      reset       = 1'b1;
      drive_beat(0, 0, 0, 0, 0, 0, 0, 0, 0);

      fd = $fopen("test/st_sink_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open test/st_sink_golden.txt");
         errors = errors + 1;
      end else begin
         size_run();

         repeat (2) @(posedge clk);
         #5;
         reset = 1'b0;

         replay_golden();
      end

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- st_sink_capture.f
+incdir+verilog
verilog/st_sink_pkg.sv
verilog/st_beat_decode.sv
verilog/st_idle_tagger.sv
verilog/st_record_fifo.sv
verilog/st_sink_capture.sv
test/st_sink_capture_tb.sv

//--- Bender.yml
package:
  name: st_sink_capture

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/st_sink_pkg.sv
      - verilog/st_beat_decode.sv
      - verilog/st_idle_tagger.sv
      - verilog/st_record_fifo.sv
      - verilog/st_sink_capture.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - test/st_sink_capture_tb.sv

//--- test/st_sink_golden.txt
# C name count valid ready_ctl pop data channel sop eop error empty   (held count cycles)
# P name idles data channel sop eop error empty   (check head, then pop)   L/V/O name value
C field 2 0 1 0 00000000 0 0 0 0 0
C field 1 1 1 0 12345678 3 1 0 0 0
C field 1 1 1 0 9abcdef0 a 0 1 2 3
C field 1 1 1 0 deadbeef f 1 1 1 1
C field 2 0 1 0 00000000 0 0 0 0 0
L field 3
P field 0 12345678 3 1 0 0 0
P field 0 9abcdef0 a 0 1 2 3
P field 0 deadbeef f 1 1 1 1
L field 0
V field 0
C order 1 1 1 0 00000011 1 1 0 0 0
C order 1 1 1 0 00000022 2 0 0 0 0
C order 1 1 1 0 00000033 3 0 0 0 0
L order 1
C order 1 1 1 0 00000044 4 0 0 0 0
C order 1 1 1 0 00000055 5 0 1 0 2
L order 3
C order 2 0 1 0 00000000 0 0 0 0 0
L order 5
P order 5 00000011 1 1 0 0 0
L order 4
P order 0 00000022 2 0 0 0 0
L order 3
P order 0 00000033 3 0 0 0 0
P order 0 00000044 4 0 0 0 0
P order 0 00000055 5 0 1 0 2
L order 0
C latency 3 0 0 0 00000000 0 0 0 0 0
C latency 2 1 0 0 bad00001 0 0 0 0 0
C latency 1 1 1 0 bad00002 0 0 0 0 0
C latency 1 1 1 0 0000cafe 6 1 1 0 0
C latency 2 0 1 0 00000000 0 0 0 0 0
L latency 1
P latency 0 0000cafe 6 1 1 0 0
L latency 0
V latency 0
C idle 1 1 1 0 00000100 0 0 0 0 0
C idle 1 1 1 0 00000101 1 0 0 0 0
C idle 3 0 1 0 00000000 0 0 0 0 0
C idle 1 1 1 0 00000102 2 0 0 0 0
C idle 6 0 1 0 00000000 0 0 0 0 0
C idle 1 1 1 0 00000103 3 0 0 0 0
C idle 2 0 0 0 00000000 0 0 0 0 0
C idle 3 0 1 0 00000000 0 0 0 0 0
C idle 1 1 1 0 00000104 4 0 0 0 0
C idle 2 0 1 0 00000000 0 0 0 0 0
L idle 5
P idle 3 00000100 0 0 0 0 0
P idle 0 00000101 1 0 0 0 0
P idle 3 00000102 2 0 0 0 0
P idle 6 00000103 3 0 0 0 0
P idle 1 00000104 4 0 0 0 0
L idle 0
C over 1 1 1 0 00000f01 1 0 0 0 0
C over 1 1 1 0 00000f02 2 0 0 0 0
C over 1 1 1 0 00000f03 3 0 0 0 0
C over 1 1 1 0 00000f04 4 0 0 0 0
C over 1 1 1 0 00000f05 5 0 0 0 0
C over 1 1 1 0 00000f06 6 0 0 0 0
C over 1 1 1 0 00000f07 7 0 0 0 0
C over 1 1 1 0 00000f08 8 0 0 0 0
C over 1 1 1 0 00000f09 9 0 0 0 0
C over 2 0 1 0 00000000 0 0 0 0 0
O over 1
L over 8
P over 7 00000f01 1 0 0 0 0
P over 0 00000f02 2 0 0 0 0
P over 0 00000f03 3 0 0 0 0
P over 0 00000f04 4 0 0 0 0
P over 0 00000f05 5 0 0 0 0
P over 0 00000f06 6 0 0 0 0
P over 0 00000f07 7 0 0 0 0
P over 0 00000f08 8 0 0 0 0
L over 0
V over 0
O over 1
C reset 1 1 1 0 0000aaaa a 1 1 0 0
C reset 2 0 1 0 00000000 0 0 0 0 0
L reset 1
X reset
V reset 0
L reset 0
O reset 0
